/* logic/pe_defines.svh */
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// array geometry
`define PE_NUM 4
`define LANE_W 2

// signed operand width, activations and weights alike
`define DATA_W 8

// psum width, wraps modulo 2**PSUM_W
`define PSUM_W 20

// tap count width, 0 is taken as 1
`define TAP_W 4

`endif

/* logic/pe_pkg.sv */
`include "pe_defines.svh"

package pe_pkg;

    // ====================
    // controller state
    // ====================
    typedef enum logic [1:0] {
        IDLE,
        INIT,
        WORK,
        STALL
    } pe_state_e;

    // ====================
    // psum opcode
    // ====================
    // fresh clears at INIT, accum keeps the last job's psum
    typedef enum logic {
        OP_FRESH,
        OP_ACCUM
    } pe_op_e;

endpackage

/* logic/datapath_controller.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module datapath_controller (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_start,
    input  pe_pkg::pe_op_e    i_op,
    input  logic [`TAP_W-1:0] i_taps,
    input  logic              i_stall,
    input  logic              i_abort,
    input  logic              i_op_valid,
    input  logic              i_draining,
    output logic              o_want,
    output logic              o_clear,
    output logic              o_mac_en,
    output logic              o_done
);

    pe_pkg::pe_state_e state_q, state_d;
    pe_pkg::pe_op_e    op_q;
    logic [`TAP_W-1:0] taps_q;
    logic [`TAP_W-1:0] tap_cnt_q;
    logic              start_ok;
    logic              last_tap;
    logic              done_q;

    // ====================
    // comb
    // ====================
    // a start is dropped during the done cycle and the drain
    assign start_ok = i_start && !i_draining && !done_q;
    assign last_tap = (tap_cnt_q == (taps_q - `TAP_W'(1)));

    // operands are registered in the dispatcher, so a mac lands one cycle
    // after its transfer; only one transfer may be in flight
    assign o_want   = (state_q == pe_pkg::WORK) && !i_stall && !i_abort && !i_op_valid;
    assign o_mac_en = i_op_valid && (state_q == pe_pkg::WORK);
    assign o_clear  = ((state_q == pe_pkg::INIT) && (op_q == pe_pkg::OP_FRESH))
                   || ((state_q != pe_pkg::IDLE) && i_abort);
    assign o_done   = done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            pe_pkg::IDLE: begin
                if (start_ok) begin
                    state_d = pe_pkg::INIT;
                end
            end
            pe_pkg::INIT: begin
                state_d = i_abort ? pe_pkg::IDLE : pe_pkg::WORK;
            end
            pe_pkg::WORK: begin
                if (i_abort) begin
                    state_d = pe_pkg::IDLE;
                end else if (o_mac_en && last_tap) begin
                    state_d = pe_pkg::IDLE;
                end else if (i_stall) begin
                    state_d = pe_pkg::STALL;
                end
            end
            pe_pkg::STALL: begin
                if (i_abort) begin
                    state_d = pe_pkg::IDLE;
                end else if (!i_stall) begin
                    state_d = pe_pkg::WORK;
                end
            end
            default: begin
                state_d = pe_pkg::IDLE;
            end
        endcase
    end

    // ====================
    // sequential
    // ====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= pe_pkg::IDLE;
            op_q      <= pe_pkg::OP_FRESH;
            taps_q    <= `TAP_W'(1);
            tap_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= o_mac_en && last_tap && !i_abort;
            if ((state_q == pe_pkg::IDLE) && start_ok) begin
                op_q      <= i_op;
                taps_q    <= (i_taps == '0) ? `TAP_W'(1) : i_taps;
                tap_cnt_q <= '0;
            end else if (o_mac_en) begin
                tap_cnt_q <= tap_cnt_q + `TAP_W'(1);
            end
        end
    end

    // ====================
    // checks
    // ====================
    a_done_single : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_done |=> !o_done);

    // an operand never lands outside WORK, so none is lost
    a_operand_in_work : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_op_valid |-> (state_q == pe_pkg::WORK));

endmodule

/* logic/pe_unit.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module pe_unit (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_start,
    input  pe_pkg::pe_op_e            i_op,
    input  logic [`TAP_W-1:0]         i_taps,
    input  logic                      i_stall,
    input  logic                      i_abort,
    input  logic                      i_op_valid,
    input  logic                      i_draining,
    input  logic signed [`DATA_W-1:0] i_act,
    input  logic signed [`DATA_W-1:0] i_weight,
    output logic                      o_want,
    output logic                      o_done,
    output logic signed [`PSUM_W-1:0] o_psum
);

    logic                        clear;
    logic                        mac_en;
    logic signed [2*`DATA_W-1:0] prod;
    logic signed [`PSUM_W-1:0]   prod_ext;
    logic signed [`PSUM_W-1:0]   psum_q;

    // per-PE copy of the job controller
    datapath_controller u_ctrl (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_start    (i_start),
        .i_op       (i_op),
        .i_taps     (i_taps),
        .i_stall    (i_stall),
        .i_abort    (i_abort),
        .i_op_valid (i_op_valid),
        .i_draining (i_draining),
        .o_want     (o_want),
        .o_clear    (clear),
        .o_mac_en   (mac_en),
        .o_done     (o_done)
    );

    // ====================
    // multiply-accumulate
    // ====================
    assign prod     = i_act * i_weight;
    assign prod_ext = {{(`PSUM_W - 2*`DATA_W){prod[2*`DATA_W-1]}}, prod};

    // clear beats mac when an abort hits a landing operand
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            psum_q <= '0;
        end else if (clear) begin
            psum_q <= '0;
        end else if (mac_en) begin
            psum_q <= psum_q + prod_ext;
        end
    end

    assign o_psum = psum_q;

endmodule

/* logic/operand_dispatcher.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module operand_dispatcher (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_in_rdy,
    input  logic signed [`DATA_W-1:0]        i_in_data,
    input  logic                             i_w_rdy,
    input  logic [`PE_NUM*`DATA_W-1:0]       i_w_data,
    input  logic [`PE_NUM-1:0]               i_want,
    output logic                             o_in_ack,
    output logic                             o_w_ack,
    output logic                             o_op_valid,
    output logic signed [`DATA_W-1:0]        o_act,
    output logic [`PE_NUM*`DATA_W-1:0]       o_weight
);

    logic                      ack;
    logic                      op_valid_q;
    logic signed [`DATA_W-1:0] act_q;
    logic [`PE_NUM*`DATA_W-1:0] weight_q;

    // ====================
    // handshake
    // ====================
    // both streams move together, only when every PE asks
    assign ack      = i_in_rdy && i_w_rdy && (&i_want);
    assign o_in_ack = ack;
    assign o_w_ack  = ack;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            op_valid_q <= 1'b0;
        end else begin
            op_valid_q <= ack;
        end
    end

    // operand hold registers
    always_ff @(posedge i_clk) begin
        if (ack) begin
            act_q    <= i_in_data;
            weight_q <= i_w_data;
        end
    end

    // activation goes to all, lanes are split at the top
    assign o_op_valid = op_valid_q;
    assign o_act      = act_q;
    assign o_weight   = weight_q;

    // a new transfer waits until the last one has landed in the PEs
    a_one_in_flight : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ack |-> !op_valid_q);

endmodule

/* logic/psum_collector.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module psum_collector (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic [`PE_NUM-1:0]          i_done,
    input  logic [`PE_NUM*`PSUM_W-1:0]  i_psum,
    output logic                        o_draining,
    output logic                        o_psum_valid,
    output logic signed [`PSUM_W-1:0]   o_psum,
    output logic [`LANE_W-1:0]          o_psum_lane,
    output logic                        o_done,
    output logic                        o_busy_end
);

    localparam logic [`LANE_W-1:0] LAST_LANE = `LANE_W'(`PE_NUM - 1);

    logic                         draining_q;
    logic [`LANE_W-1:0]           lane_q;
    logic [`PE_NUM*`PSUM_W-1:0]   snap_q;
    logic                         last_lane;

    // ====================
    // capture and drain
    // ====================
    // lanes run in lockstep, lane 0 speaks for all
    always_ff @(posedge i_clk) begin
        if (i_done[0]) begin
            snap_q <= i_psum;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            draining_q <= 1'b0;
            lane_q     <= '0;
        end else if (i_done[0]) begin
            draining_q <= 1'b1;
            lane_q     <= '0;
        end else if (draining_q) begin
            if (last_lane) begin
                draining_q <= 1'b0;
            end
            lane_q <= lane_q + `LANE_W'(1);
        end
    end

    assign last_lane    = draining_q && (lane_q == LAST_LANE);
    assign o_draining   = draining_q;
    assign o_psum_valid = draining_q;
    assign o_psum_lane  = lane_q;
    assign o_psum       = snap_q[lane_q*`PSUM_W +: `PSUM_W];
    assign o_done       = last_lane;
    // job is over for the busy flag once the last lane is out
    assign o_busy_end   = last_lane;

    // ====================
    // checks
    // ====================
    a_done_lockstep : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_done == {`PE_NUM{1'b0}}) || (i_done == {`PE_NUM{1'b1}}));

    a_no_capture_in_drain : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_done[0] |-> !draining_q);

endmodule

/* logic/pe_array_top.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module pe_array_top (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_start,
    input  pe_pkg::pe_op_e              i_op,
    input  logic [`TAP_W-1:0]           i_taps,
    input  logic                        i_stall,
    input  logic                        i_abort,
    input  logic                        i_in_rdy,
    input  logic signed [`DATA_W-1:0]   i_in_data,
    output logic                        o_in_ack,
    input  logic                        i_w_rdy,
    input  logic [`PE_NUM*`DATA_W-1:0]  i_w_data,
    output logic                        o_w_ack,
    output logic                        o_psum_valid,
    output logic signed [`PSUM_W-1:0]   o_psum,
    output logic [`LANE_W-1:0]          o_psum_lane,
    output logic                        o_done,
    output logic                        o_busy
);

    logic [`PE_NUM-1:0]          want;
    logic [`PE_NUM-1:0]          pe_done;
    logic [`PE_NUM*`PSUM_W-1:0]  pe_psum;
    logic [`PE_NUM*`DATA_W-1:0]  weight;
    logic signed [`DATA_W-1:0]   act;
    logic                        op_valid;
    logic                        draining;
    logic                        busy_end;
    logic                        busy_q;

    operand_dispatcher u_dispatch (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_in_rdy   (i_in_rdy),
        .i_in_data  (i_in_data),
        .i_w_rdy    (i_w_rdy),
        .i_w_data   (i_w_data),
        .i_want     (want),
        .o_in_ack   (o_in_ack),
        .o_w_ack    (o_w_ack),
        .o_op_valid (op_valid),
        .o_act      (act),
        .o_weight   (weight)
    );

    // ====================
    // pe lanes
    // ====================
    for (genvar p = 0; p < `PE_NUM; p++) begin : g_pe
        pe_unit u_pe (
            .i_clk      (i_clk),
            .i_arst_n   (i_arst_n),
            .i_start    (i_start),
            .i_op       (i_op),
            .i_taps     (i_taps),
            .i_stall    (i_stall),
            .i_abort    (i_abort),
            .i_op_valid (op_valid),
            .i_draining (draining),
            .i_act      (act),
            .i_weight   (weight[p*`DATA_W +: `DATA_W]),
            .o_want     (want[p]),
            .o_done     (pe_done[p]),
            .o_psum     (pe_psum[p*`PSUM_W +: `PSUM_W])
        );
    end

    psum_collector u_collect (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_done       (pe_done),
        .i_psum       (pe_psum),
        .o_draining   (draining),
        .o_psum_valid (o_psum_valid),
        .o_psum       (o_psum),
        .o_psum_lane  (o_psum_lane),
        .o_done       (o_done),
        .o_busy_end   (busy_end)
    );

    // busy flag, an abort outside the drain also ends the job
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= 1'b0;
        end else if (i_start && !busy_q) begin
            busy_q <= 1'b1;
        end else if (busy_end || (i_abort && !draining)) begin
            busy_q <= 1'b0;
        end
    end

    assign o_busy = busy_q;

endmodule

/* tests/pe_array_tb.sv */
`timescale 1ns/1ps
`include "pe_defines.svh"

module pe_array_tb;

    typedef struct packed {
        pe_pkg::pe_op_e    op;
        logic [`TAP_W-1:0] taps;
        logic [`TAP_W-1:0] stall_at;
        logic              abort;
        logic              gaps;
    } job_row_t;

    localparam int N_JOBS    = 10;
    localparam int ROW_SLACK = 30;
    localparam int STALL_LEN = 6;

    // ====================
    // job table
    // ====================
    // op, taps, stall after n transfers (0 none), abort, rdy gaps
    job_row_t jobs [N_JOBS] = '{
        '{pe_pkg::OP_FRESH, 4'd4,  4'd0, 1'b0, 1'b0},
        '{pe_pkg::OP_ACCUM, 4'd6,  4'd0, 1'b0, 1'b1},
        '{pe_pkg::OP_FRESH, 4'd8,  4'd3, 1'b0, 1'b0},
        '{pe_pkg::OP_ACCUM, 4'd10, 4'd5, 1'b0, 1'b1},
        '{pe_pkg::OP_FRESH, 4'd6,  4'd0, 1'b1, 1'b0},
        '{pe_pkg::OP_ACCUM, 4'd5,  4'd0, 1'b0, 1'b1},
        '{pe_pkg::OP_FRESH, 4'd15, 4'd7, 1'b0, 1'b1},
        '{pe_pkg::OP_ACCUM, 4'd0,  4'd0, 1'b0, 1'b0},
        '{pe_pkg::OP_ACCUM, 4'd12, 4'd0, 1'b1, 1'b1},
        '{pe_pkg::OP_ACCUM, 4'd3,  4'd2, 1'b0, 1'b0}
    };

    logic                             i_clk;
    logic                             i_arst_n;
    logic                             i_start;
    pe_pkg::pe_op_e                   i_op;
    logic [`TAP_W-1:0]                i_taps;
    logic                             i_stall;
    logic                             i_abort;
    logic                             i_in_rdy;
    logic signed [`DATA_W-1:0]        i_in_data;
    logic                             o_in_ack;
    logic                             i_w_rdy;
    logic [`PE_NUM*`DATA_W-1:0]       i_w_data;
    logic                             o_w_ack;
    logic                             o_psum_valid;
    logic signed [`PSUM_W-1:0]        o_psum;
    logic [`LANE_W-1:0]               o_psum_lane;
    logic                             o_done;
    logic                             o_busy;

    // reference psum per lane
    logic signed [`PSUM_W-1:0] ref_psum [`PE_NUM];
    int seed = 89873;

    pe_array_top i_dut (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_start      (i_start),
        .i_op         (i_op),
        .i_taps       (i_taps),
        .i_stall      (i_stall),
        .i_abort      (i_abort),
        .i_in_rdy     (i_in_rdy),
        .i_in_data    (i_in_data),
        .o_in_ack     (o_in_ack),
        .i_w_rdy      (i_w_rdy),
        .i_w_data     (i_w_data),
        .o_w_ack      (o_w_ack),
        .o_psum_valid (o_psum_valid),
        .o_psum       (o_psum),
        .o_psum_lane  (o_psum_lane),
        .o_done       (o_done),
        .o_busy       (o_busy)
    );

    always #5 i_clk = ~i_clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // ====================
    // one job from the table
    // ====================
    task automatic run_job(input int r);
        job_row_t                   row;
        int                         n_taps, abort_at, sent, acks;
        int                         gap_left, stall_left, lane_next, after_abort, prod;
        bit                         pending, xfer, stalled_once, aborted, finished;
        logic [31:0]                rnd;
        logic signed [`DATA_W-1:0]  act;
        logic signed [`DATA_W-1:0]  w;
        logic [`PE_NUM*`DATA_W-1:0] wts;
        row = jobs[r];
        n_taps = (row.taps == '0) ? 1 : int'(row.taps);
        abort_at = row.abort ? n_taps / 2 : -1;
        sent = 0;
        acks = 0;
        stall_left = 0;
        lane_next = 0;
        after_abort = 0;
        pending = 1'b0;
        xfer = 1'b0;
        stalled_once = 1'b0;
        aborted = 1'b0;
        finished = 1'b0;
        act = '0;
        wts = '0;
        gap_left = row.gaps ? ($random(seed) & 3) : 0;
        if (row.op == pe_pkg::OP_FRESH) begin
            for (int l = 0; l < `PE_NUM; l++) ref_psum[l] = '0;
        end
        $display("job %0d: %s, %0d taps", r, (row.op == pe_pkg::OP_FRESH) ? "fresh" : "accum",
                 n_taps);
        @(posedge i_clk);
        i_start <= 1'b1;
        i_op    <= row.op;
        i_taps  <= row.taps;
        while (!finished) begin
            @(posedge i_clk);
            i_start <= 1'b0;
            // the ack seen last negedge completed at this edge
            if (xfer) begin
                sent++;
                pending = 1'b0;
                for (int l = 0; l < `PE_NUM; l++) begin
                    w = wts[l*`DATA_W +: `DATA_W];
                    prod = int'(act) * int'(w);
                    ref_psum[l] = ref_psum[l] + prod[`PSUM_W-1:0];
                end
                gap_left = row.gaps ? ($random(seed) & 3) : 0;
            end
            if (row.stall_at != '0 && !stalled_once && sent == int'(row.stall_at)) begin
                stalled_once = 1'b1;
                stall_left = STALL_LEN;
                i_stall <= 1'b1;
            end else if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) i_stall <= 1'b0;
            end
            if (!aborted && sent == abort_at) begin
                aborted = 1'b1;
                i_abort <= 1'b1;
                for (int l = 0; l < `PE_NUM; l++) ref_psum[l] = '0;
            end else if (aborted) begin
                after_abort++;
                if (after_abort == 2) i_abort <= 1'b0;
                if (after_abort == 10) finished = 1'b1;
            end
            // operand source, holds rdy and data until acked
            if (!pending && !aborted && sent < n_taps) begin
                if (gap_left > 0) begin
                    gap_left--;
                    i_in_rdy <= 1'b0;
                    i_w_rdy  <= 1'b0;
                end else begin
                    rnd = $random(seed);
                    act = rnd[`DATA_W-1:0];
                    rnd = $random(seed);
                    wts = rnd[`PE_NUM*`DATA_W-1:0];
                    pending = 1'b1;
                    i_in_rdy  <= 1'b1;
                    i_w_rdy   <= 1'b1;
                    i_in_data <= act;
                    i_w_data  <= wts;
                end
            end else if (!pending) begin
                i_in_rdy <= 1'b0;
                i_w_rdy  <= 1'b0;
            end
            @(negedge i_clk);
            xfer = o_in_ack;
            assert (o_in_ack == o_w_ack) else stop_run("activation and weight acks differ");
            if (o_in_ack) begin
                acks++;
                assert (pending) else stop_run("ack given with no operand offered");
                assert (!i_stall) else stop_run("ack given while stall is high");
            end
            if (o_psum_valid) begin
                assert (!aborted) else stop_run("psum strobe after an aborted job");
                assert (o_psum_lane == `LANE_W'(lane_next)) else stop_run($sformatf(
                    "mismatch at %0t: lane %0d out, expected lane %0d",
                    $time, o_psum_lane, lane_next));
                assert (o_psum == ref_psum[o_psum_lane]) else stop_run($sformatf(
                    "mismatch at %0t: lane %0d psum %0d, expected %0d",
                    $time, o_psum_lane, o_psum, ref_psum[o_psum_lane]));
                assert (o_done == (lane_next == `PE_NUM - 1))
                    else stop_run("done pulse not aligned with the last lane");
                lane_next++;
            end else begin
                assert (!o_done) else stop_run("done pulse without a psum strobe");
            end
            if (!aborted) begin
                assert (o_busy) else stop_run("busy dropped while the job was running");
            end
            if (o_done) finished = 1'b1;
        end
        assert (acks == (row.abort ? abort_at : n_taps)) else stop_run($sformatf(
            "mismatch at %0t: %0d transfers acked, expected %0d",
            $time, acks, row.abort ? abort_at : n_taps));
        assert (lane_next == (row.abort ? 0 : `PE_NUM))
            else stop_run("wrong number of psum strobes for the job");
        @(negedge i_clk);
        assert (!o_busy) else stop_run("busy still high after the job ended");
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        pe_pkg::pe_state_e st0;
        i_clk     = 1'b0;
        i_arst_n  = 1'b0;
        i_start   = 1'b0;
        i_op      = pe_pkg::OP_FRESH;
        i_taps    = '0;
        i_stall   = 1'b0;
        i_abort   = 1'b0;
        i_in_rdy  = 1'b0;
        i_in_data = '0;
        i_w_rdy   = 1'b0;
        i_w_data  = '0;
        for (int l = 0; l < `PE_NUM; l++) ref_psum[l] = '0;
        repeat (4) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        st0 = i_dut.g_pe[0].u_pe.u_ctrl.state_q;
        $display("pe 0 controller after reset: %s", st0.name());
        assert (!o_busy && !o_in_ack && !o_w_ack && !o_psum_valid && !o_done)
            else stop_run("outputs not quiet after reset");
        for (int r = 0; r < N_JOBS; r++) run_job(r);
        $display("Test completed successfully");
        $finish;
    end

    // watchdog, budget from the table's tap counts
    initial begin
        int budget;
        budget = 0;
        for (int r = 0; r < N_JOBS; r++) budget += int'(jobs[r].taps) + ROW_SLACK;
        budget = budget * 20;
        repeat (budget) @(posedge i_clk);
        stop_run($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
                           budget));
    end

endmodule

/* verilog.f */
+incdir+logic
logic/pe_pkg.sv
logic/datapath_controller.sv
logic/pe_unit.sv
logic/operand_dispatcher.sv
logic/psum_collector.sv
logic/pe_array_top.sv
tests/pe_array_tb.sv

/* Makefile */
# Verilator flow for the PE array testbench

VERILATOR ?= verilator
TOP       ?= pe_array_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
